//--- ising_core_top.f
+incdir+src
src/ising_pkg.sv
src/ising_load_if.sv
src/ising_apb_regs.sv
src/ising_field_engine.sv
src/ising_flip_sequencer.sv
src/ising_spin_update.sv
src/ising_core_top.sv
verif/ising_core_assertions.sv
verif/ising_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := ising_core_tb
RTL_TOP   := ising_core_top
FILELIST  := ising_core_top.f
FLAGS     := --binary --timing --assert -Wno-fatal
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# the log decides pass or fail
run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/ising_core_tb.sv
`timescale 1ns/1ps
`include "ising_settings.svh"

module ising_core_tb import ising_pkg::*; ();

    localparam int        NUM_RUNS      = 11;   // runs started over all tests
    localparam int        DONE_LIMIT    = `ISING_FLIP_DEPTH * 20 + 40;  // cycles
    localparam int        WATCHDOG_NS   = NUM_RUNS * 16 * 20 * 8 + 40000;
    localparam apb_addr_t UNMAPPED_ADDR = 12'h300;

    logic      clk;
    logic      rst_n;
    logic      psel, penable, pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata, prdata;
    logic      pready, pslverr, done;

    logic [31:0] rng_state;
    int          mismatch_count;
    int          failure_count;

    // reference copy of what the core holds
    logic [63:0] ref_j [`ISING_NUM_SPIN];
    logic [63:0] ref_h;
    spin_vec_t   ref_mask [`ISING_FLIP_DEPTH];

    ising_core_top ising_core_top_i (
        .clk_i     (clk    ),
        .rst_n_i   (rst_n  ),
        .psel_i    (psel   ),
        .penable_i (penable),
        .pwrite_i  (pwrite ),
        .paddr_i   (paddr  ),
        .pwdata_i  (pwdata ),
        .prdata_o  (prdata ),
        .pready_o  (pready ),
        .pslverr_o (pslverr),
        .done_o    (done   )
    );

    always #4 clk = ~clk;   // 8 ns period

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic report_mismatch(input string test, input apb_data_t expected,
                                   input apb_data_t actual);
        $display("MISMATCH %s: expected %h, actual %h", test, expected, actual);
        mismatch_count++;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // apb transfers, setup cycle then access cycle
    ////////////////////////////////////////////////////////////////////////////
    task automatic apb_write(input apb_addr_t addr, input apb_data_t data,
                             input logic expect_err);
        @(posedge clk);
        #1;
        psel   = 1'b1;
        pwrite = 1'b1;
        paddr  = addr;
        pwdata = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);     // mid access cycle
        if (pready !== 1'b1) begin
            $display("pready_o low in the access cycle of a write to %h", addr);
            failure_count++;
        end
        if (pslverr !== expect_err) begin
            $display("write to %h gave slave error %b, expected %b", addr, pslverr, expect_err);
            failure_count++;
        end
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data,
                            input logic expect_err);
        @(posedge clk);
        #1;
        psel   = 1'b1;
        pwrite = 1'b0;
        paddr  = addr;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        data = prdata;
        if (pready !== 1'b1) begin
            $display("pready_o low in the access cycle of a read of %h", addr);
            failure_count++;
        end
        if (pslverr !== expect_err) begin
            $display("read of %h gave slave error %b, expected %b", addr, pslverr, expect_err);
            failure_count++;
        end
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // random J, h and flip masks into both the core and the model
    task automatic load_random_config(input int icons);
        logic [31:0] lo;
        logic [31:0] hi;
        logic [31:0] m;
        for (int r = 0; r < `ISING_NUM_SPIN; r++) begin
            lo = next_random();
            hi = next_random();
            ref_j[r] = {hi, lo};
            apb_write(`ISING_J_BASE + apb_addr_t'(8 * r), lo, 1'b0);
            apb_write(`ISING_J_BASE + apb_addr_t'(8 * r + 4), hi, 1'b0);
        end
        lo = next_random();
        hi = next_random();
        ref_h = {hi, lo};
        apb_write(`ISING_REG_HBIAS_LO, lo, 1'b0);
        apb_write(`ISING_REG_HBIAS_HI, hi, 1'b0);
        for (int k = 0; k < `ISING_FLIP_DEPTH; k++) begin
            m = next_random();
            ref_mask[k] = m[15:0];
            apb_write(`ISING_FLIP_BASE + apb_addr_t'(4 * k), m, 1'b0);
        end
        apb_write(`ISING_REG_ICON_COUNT, apb_data_t'(icons), 1'b0);
    endtask

    // synchronous sweeps on the old spins, then xor with the flip mask
    function automatic spin_vec_t model_run(input spin_vec_t start, input int icons);
        spin_vec_t s;
        spin_vec_t nxt;
        int        field;
        int        w;
        s = start;
        for (int it = 0; it < icons; it++) begin
            for (int i = 0; i < `ISING_NUM_SPIN; i++) begin
                field = int'($signed(ref_h[4*i +: 4]));
                for (int k = 0; k < `ISING_NUM_SPIN; k++) begin
                    w     = int'($signed(ref_j[i][4*k +: 4]));
                    field = s[k] ? field + w : field - w;
                end
                nxt[i] = (field >= 0);   // zero field gives +1
            end
            s = nxt ^ ref_mask[it];
        end
        return s;
    endfunction

    task automatic start_run();
        apb_write(`ISING_REG_CTRL, 32'h1, 1'b0);
    endtask

    task automatic wait_done(input string test);
        int cycles;
        cycles = 0;
        while (done !== 1'b1 && cycles < DONE_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (done !== 1'b1) begin
            $display("%s: done_o did not rise within %0d cycles", test, DONE_LIMIT);
            failure_count++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        spin_vec_t spins0;
        spin_vec_t expected;
        apb_data_t rdata;
        int        icons;
        string     name;
        clk            = 1'b0;
        rst_n          = 1'b0;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        paddr          = '0;
        pwdata         = '0;
        rng_state      = 32'd74404;
        mismatch_count = 0;
        failure_count  = 0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // reset_state
        if (done !== 1'b0) report_mismatch("reset_state done_o", 32'h0, apb_data_t'(done));
        apb_read(`ISING_REG_STATUS, rdata, 1'b0);
        if (rdata !== 32'h0) report_mismatch("reset_state STATUS", 32'h0, rdata);
        apb_read(`ISING_REG_SPINS, rdata, 1'b0);
        if (rdata !== 32'h0) report_mismatch("reset_state SPINS", 32'h0, rdata);

        // single_iteration
        load_random_config(1);
        spins0 = spin_vec_t'(next_random());
        apb_write(`ISING_REG_SPINS, apb_data_t'(spins0), 1'b0);   // also clears done
        start_run();
        wait_done("single_iteration");
        expected = model_run(spins0, 1);
        apb_read(`ISING_REG_SPINS, rdata, 1'b0);
        if (rdata !== apb_data_t'(expected)) begin
            report_mismatch("single_iteration", apb_data_t'(expected), rdata);
        end

        // multi_iteration
        for (int t = 0; t < 8; t++) begin
            name  = $sformatf("multi_iteration trial %0d", t);
            icons = 1 + int'(next_random() % 32'd16);
            load_random_config(icons);
            spins0 = spin_vec_t'(next_random());
            apb_write(`ISING_REG_SPINS, apb_data_t'(spins0), 1'b0);
            start_run();
            wait_done(name);
            expected = model_run(spins0, icons);
            apb_read(`ISING_REG_SPINS, rdata, 1'b0);
            if (rdata !== apb_data_t'(expected)) report_mismatch(name, apb_data_t'(expected), rdata);
            apb_read(`ISING_REG_STATUS, rdata, 1'b0);
            if (rdata !== 32'h2) report_mismatch({name, " STATUS"}, 32'h2, rdata);
        end

        // ICON_COUNT above the flip depth reads back as 16
        apb_write(`ISING_REG_ICON_COUNT, 32'h21, 1'b0);
        apb_read(`ISING_REG_ICON_COUNT, rdata, 1'b0);
        if (rdata !== 32'h10) report_mismatch("icon_clip", 32'h10, rdata);

        // zero_icons
        apb_write(`ISING_REG_ICON_COUNT, 32'h0, 1'b0);
        spins0 = spin_vec_t'(next_random());
        apb_write(`ISING_REG_SPINS, apb_data_t'(spins0), 1'b0);
        start_run();
        wait_done("zero_icons");
        apb_read(`ISING_REG_SPINS, rdata, 1'b0);
        if (rdata !== apb_data_t'(spins0)) report_mismatch("zero_icons", apb_data_t'(spins0), rdata);

        // bus_errors
        apb_read(UNMAPPED_ADDR, rdata, 1'b1);
        apb_read(`ISING_J_BASE, rdata, 1'b1);     // J is write-only
        apb_write(`ISING_REG_ICON_COUNT, 32'h4, 1'b0);
        spins0 = spin_vec_t'(next_random());
        apb_write(`ISING_REG_SPINS, apb_data_t'(spins0), 1'b0);
        start_run();
        apb_write(`ISING_J_BASE, next_random(), 1'b1);   // core busy, must be dropped
        wait_done("bus_errors");
        expected = model_run(spins0, 4);
        apb_read(`ISING_REG_SPINS, rdata, 1'b0);
        if (rdata !== apb_data_t'(expected)) report_mismatch("bus_errors", apb_data_t'(expected), rdata);

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // watchdog, sized for every run at the full 16 iterations
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- verif/ising_core_assertions.sv
`timescale 1ns/1ps

module ising_core_assertions (
    input logic clk_i,
    input logic rst_n_i,
    input logic psel_i,
    input logic penable_i,
    input logic pready_i,
    input logic pslverr_i,
    input logic done_i,
    input logic busy_i
);

    pready_high: assert property (@(posedge clk_i) pready_i)
        else $error("pready_o went low");

    // error response only in the access phase
    pslverr_access: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pslverr_i |-> (psel_i && penable_i))
        else $error("pslverr_o outside an access cycle");

    done_after_reset: assert property (@(posedge clk_i) !rst_n_i |=> !done_i)
        else $error("done_o high in the cycle after reset");

    done_not_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(done_i && busy_i))
        else $error("done_o high while the core is busy");

endmodule

bind ising_core_top ising_core_assertions ising_core_assertions_i (
    .clk_i     (clk_i    ),
    .rst_n_i   (rst_n_i  ),
    .psel_i    (psel_i   ),
    .penable_i (penable_i),
    .pready_i  (pready_o ),
    .pslverr_i (pslverr_o),
    .done_i    (done_o   ),
    .busy_i    (busy     )
);

//--- src/ising_core_top.sv
`timescale 1ns/1ps

module ising_core_top import ising_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      psel_i,
    input  logic      penable_i,
    input  logic      pwrite_i,
    input  apb_addr_t paddr_i,
    input  apb_data_t pwdata_i,
    output apb_data_t prdata_o,
    output logic      pready_o,
    output logic      pslverr_o,
    output logic      done_o
);

    logic      busy;
    logic      start;
    logic      spin_load;
    spin_vec_t spin_wdata;
    spin_vec_t spins;
    h_vec_t    h_vec;
    icon_cnt_t icon_count;
    logic      sweep_start, sweep_done;
    spin_vec_t new_spins;
    logic      restart, advance;
    spin_vec_t mask;
    logic      none_left;

    ising_load_if load_bus ();  // memory writes from the register block

    ising_apb_regs u_apb_regs (
        .clk_i        (clk_i      ),
        .rst_n_i      (rst_n_i    ),
        .psel_i       (psel_i     ),
        .penable_i    (penable_i  ),
        .pwrite_i     (pwrite_i   ),
        .paddr_i      (paddr_i    ),
        .pwdata_i     (pwdata_i   ),
        .prdata_o     (prdata_o   ),
        .pready_o     (pready_o   ),
        .pslverr_o    (pslverr_o  ),
        .load         (load_bus   ),
        .busy_i       (busy       ),
        .done_i       (done_o     ),
        .spins_i      (spins      ),
        .start_o      (start      ),
        .spin_load_o  (spin_load  ),
        .spin_wdata_o (spin_wdata ),
        .h_o          (h_vec      ),
        .icon_count_o (icon_count )
    );

    ising_field_engine u_field_engine (
        .clk_i         (clk_i       ),
        .rst_n_i       (rst_n_i     ),
        .load          (load_bus    ),
        .h_i           (h_vec       ),
        .spins_i       (spins       ),
        .sweep_start_i (sweep_start ),
        .new_spins_o   (new_spins   ),
        .sweep_done_o  (sweep_done  )
    );

    ising_flip_sequencer u_flip_sequencer (
        .clk_i        (clk_i      ),
        .rst_n_i      (rst_n_i    ),
        .load         (load_bus   ),
        .icon_count_i (icon_count ),
        .restart_i    (restart    ),
        .advance_i    (advance    ),
        .mask_o       (mask       ),
        .none_left_o  (none_left  )
    );

    ising_spin_update u_spin_update (
        .clk_i         (clk_i       ),
        .rst_n_i       (rst_n_i     ),
        .start_i       (start       ),
        .spin_load_i   (spin_load   ),
        .spin_wdata_i  (spin_wdata  ),
        .new_spins_i   (new_spins   ),
        .sweep_done_i  (sweep_done  ),
        .mask_i        (mask        ),
        .none_left_i   (none_left   ),
        .spins_o       (spins       ),
        .sweep_start_o (sweep_start ),
        .restart_o     (restart     ),
        .advance_o     (advance     ),
        .busy_o        (busy        ),
        .done_o        (done_o      )
    );

endmodule

//--- src/ising_spin_update.sv
`timescale 1ns/1ps

module ising_spin_update import ising_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      start_i,
    input  logic      spin_load_i,
    input  spin_vec_t spin_wdata_i,
    input  spin_vec_t new_spins_i,
    input  logic      sweep_done_i,
    input  spin_vec_t mask_i,
    input  logic      none_left_i,
    output spin_vec_t spins_o,
    output logic      sweep_start_o,
    output logic      restart_o,
    output logic      advance_o,
    output logic      busy_o,
    output logic      done_o
);

    core_state_t state_q, state_d;
    spin_vec_t   spins_q;
    logic        launch_q;    // flip index check due in IDLE
    logic        done_q;
    logic        idle_start;
    logic        launch_go;

    assign idle_start = (state_q == IDLE) && !launch_q && start_i;
    assign launch_go  = (state_q == IDLE) && launch_q && !none_left_i;

    ////////////////////////////////////////////////////////////////////////////
    // run FSM, one iteration is launch + 18 sweep + apply = 20 cycles
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (launch_go) begin
                    state_d = SWEEP;
                end
            end
            SWEEP: begin
                if (sweep_done_i) begin
                    state_d = APPLY;
                end
            end
            APPLY: begin
                state_d = IDLE;       // back to the index check
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q  <= IDLE;
            launch_q <= 1'b0;
            done_q   <= 1'b0;
            spins_q  <= '0;
        end else begin
            state_q <= state_d;
            if (idle_start) begin
                launch_q <= 1'b1;
                done_q   <= 1'b0;
            end else if (state_q == APPLY) begin
                launch_q <= 1'b1;
            end else if (launch_q) begin
                launch_q <= 1'b0;
                done_q   <= none_left_i;   // run over
            end
            if (state_q == APPLY) begin
                spins_q <= new_spins_i ^ mask_i;
            end else if (spin_load_i && !busy_o) begin
                spins_q <= spin_wdata_i;
                done_q  <= 1'b0;
            end
        end
    end

    assign restart_o     = idle_start;      // index back to entry 0
    assign sweep_start_o = launch_go;
    assign advance_o     = (state_q == APPLY);
    assign busy_o        = launch_q || (state_q != IDLE);
    assign done_o        = done_q;
    assign spins_o       = spins_q;

endmodule

//--- src/ising_flip_sequencer.sv
`timescale 1ns/1ps
`include "ising_settings.svh"

module ising_flip_sequencer import ising_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    ising_load_if.sequencer load,
    input  icon_cnt_t icon_count_i,
    input  logic      restart_i,
    input  logic      advance_i,
    output spin_vec_t mask_o,
    output logic      none_left_o
);

    spin_vec_t flip_mem [`ISING_FLIP_DEPTH];
    row_idx_t  wr_entry;
    icon_cnt_t idx_q;   // current iteration

    assign wr_entry = row_idx_t'(load.waddr >> 2); // one word per entry

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int e = 0; e < `ISING_FLIP_DEPTH; e++) begin
                flip_mem[e] <= '0;
            end
        end else if (load.flip_wen) begin
            flip_mem[wr_entry] <= spin_vec_t'(load.wdata);  // low 16 bits
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            idx_q <= '0;
        end else if (restart_i) begin
            idx_q <= '0;
        end else if (advance_i) begin
            idx_q <= idx_q + 1'b1;
        end
    end

    assign mask_o      = flip_mem[row_idx_t'(idx_q)];
    // >= so a lowered count mid-run still ends it
    assign none_left_o = (idx_q >= icon_count_i);

endmodule

//--- src/ising_field_engine.sv
`timescale 1ns/1ps
`include "ising_settings.svh"

module ising_field_engine import ising_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    ising_load_if.engine load,
    input  h_vec_t     h_i,
    input  spin_vec_t  spins_i,
    input  logic       sweep_start_i,
    output spin_vec_t  new_spins_o,
    output logic       sweep_done_o
);

    j_row_t    j_mem [`ISING_NUM_SPIN];
    row_idx_t  load_row;
    spin_vec_t snap_q;         // spins frozen for the whole sweep
    logic      rd_active_q;
    row_idx_t  rd_row_q;       // stage one row
    j_row_t    row_q;
    row_idx_t  row_idx_q;      // stage two row
    logic      row_vld_q;
    field_t    field;
    spin_vec_t new_spins_q;
    logic      sweep_done_q;

    assign load_row = row_idx_t'(load.waddr >> 3); // 8 bytes per row

    // coupling memory, written in 32 bit halves
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int r = 0; r < `ISING_NUM_SPIN; r++) begin
                j_mem[r] <= '0;
            end
        end else if (load.j_wen) begin
            if (load.waddr[2]) begin
                j_mem[load_row][`ISING_APB_DATA_WIDTH +: `ISING_APB_DATA_WIDTH] <= load.wdata;
            end else begin
                j_mem[load_row][0 +: `ISING_APB_DATA_WIDTH] <= load.wdata;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stage one, row read
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        row_q <= j_mem[rd_row_q];
        if (sweep_start_i) begin
            snap_q <= spins_i;
        end
    end

    // stage two, field = h[i] + sum_k J[i][k] * s[k]
    always_comb begin
        logic [`ISING_BIT_H-1:0] h_raw;
        j_weight_t               w;
        field_t                  w_ext;
        h_raw = h_i[row_idx_q*`ISING_BIT_H +: `ISING_BIT_H];
        field = field_t'($signed(h_raw));
        for (int k = 0; k < `ISING_NUM_SPIN; k++) begin
            w     = row_q[k*`ISING_BIT_J +: `ISING_BIT_J];
            w_ext = field_t'($signed(w));
            field = snap_q[k] ? field + w_ext : field - w_ext;   // spin bit 0 is -1
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rd_active_q  <= 1'b0;
            rd_row_q     <= '0;
            row_vld_q    <= 1'b0;
            row_idx_q    <= '0;
            new_spins_q  <= '0;
            sweep_done_q <= 1'b0;
        end else begin
            row_vld_q    <= rd_active_q;
            row_idx_q    <= rd_row_q;
            sweep_done_q <= row_vld_q && (row_idx_q == row_idx_t'(`ISING_NUM_SPIN - 1));
            if (sweep_start_i) begin
                rd_active_q <= 1'b1;
                rd_row_q    <= '0;
            end else if (rd_active_q) begin
                rd_row_q <= rd_row_q + 1'b1;
                if (rd_row_q == row_idx_t'(`ISING_NUM_SPIN - 1)) begin
                    rd_active_q <= 1'b0;
                end
            end
            if (row_vld_q) begin
                new_spins_q[row_idx_q] <= ~field[`ISING_FIELD_WIDTH-1]; // zero counts as +1
            end
        end
    end

    assign new_spins_o  = new_spins_q;
    assign sweep_done_o = sweep_done_q;

endmodule

//--- src/ising_apb_regs.sv
`timescale 1ns/1ps
`include "ising_settings.svh"

module ising_apb_regs import ising_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      psel_i,
    input  logic      penable_i,
    input  logic      pwrite_i,
    input  apb_addr_t paddr_i,
    input  apb_data_t pwdata_i,
    output apb_data_t prdata_o,
    output logic      pready_o,
    output logic      pslverr_o,
    ising_load_if.regs load,
    input  logic      busy_i,
    input  logic      done_i,
    input  spin_vec_t spins_i,
    output logic      start_o,
    output logic      spin_load_o,
    output spin_vec_t spin_wdata_o,
    output h_vec_t    h_o,
    output icon_cnt_t icon_count_o
);

    logic      access;
    logic      aligned;
    logic      hit_ctrl, hit_status, hit_icon, hit_spins;
    logic      hit_hlo, hit_hhi, hit_j, hit_flip;
    logic      mapped;
    logic      guarded;     // no writes while a run is going
    logic      write_only;
    logic      err;
    logic      wr_ok;
    h_vec_t    h_q;
    icon_cnt_t icon_q;
    icon_cnt_t icon_wr;

    assign access   = psel_i & penable_i;
    assign pready_o = 1'b1; // zero wait states

    ////////////////////////////////////////////////////////////////////////////
    // address decode
    ////////////////////////////////////////////////////////////////////////////
    assign aligned    = (paddr_i[1:0] == 2'b00);
    assign hit_ctrl   = (paddr_i == `ISING_REG_CTRL);
    assign hit_status = (paddr_i == `ISING_REG_STATUS);
    assign hit_icon   = (paddr_i == `ISING_REG_ICON_COUNT);
    assign hit_spins  = (paddr_i == `ISING_REG_SPINS);
    assign hit_hlo    = (paddr_i == `ISING_REG_HBIAS_LO);
    assign hit_hhi    = (paddr_i == `ISING_REG_HBIAS_HI);
    assign hit_j      = aligned && (paddr_i >= `ISING_J_BASE)
                        && (paddr_i < `ISING_J_BASE + 8 * `ISING_NUM_SPIN);
    assign hit_flip   = aligned && (paddr_i >= `ISING_FLIP_BASE)
                        && (paddr_i < `ISING_FLIP_BASE + 4 * `ISING_FLIP_DEPTH);

    assign mapped     = hit_ctrl | hit_status | hit_icon | hit_spins
                        | hit_hlo | hit_hhi | hit_j | hit_flip;
    assign guarded    = hit_spins | hit_hlo | hit_hhi | hit_j | hit_flip;
    assign write_only = hit_hlo | hit_hhi | hit_j | hit_flip;

    assign err = !mapped
                 || (pwrite_i && busy_i && guarded)
                 || (!pwrite_i && write_only);

    assign pslverr_o = access & err;
    assign wr_ok     = access & pwrite_i & !err;

    // clip to the flip memory depth, compared on the full bus word
    assign icon_wr = (pwdata_i > `ISING_FLIP_DEPTH)
                     ? icon_cnt_t'(`ISING_FLIP_DEPTH) : icon_cnt_t'(pwdata_i);

    // read data, valid in the access cycle
    always_comb begin
        prdata_o = '0;
        if (access && !pwrite_i) begin
            if (hit_status) begin
                prdata_o = apb_data_t'({done_i, busy_i});
            end else if (hit_icon) begin
                prdata_o = apb_data_t'(icon_q);
            end else if (hit_spins) begin
                prdata_o = apb_data_t'(spins_i);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // registers and write pulses
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            start_o       <= 1'b0;
            spin_load_o   <= 1'b0;
            load.j_wen    <= 1'b0;
            load.flip_wen <= 1'b0;
            h_q           <= '0;
            icon_q        <= '0;
        end else begin
            start_o       <= wr_ok && hit_ctrl && pwdata_i[0] && !busy_i;
            spin_load_o   <= wr_ok && hit_spins;
            load.j_wen    <= wr_ok && hit_j;
            load.flip_wen <= wr_ok && hit_flip;
            if (wr_ok && hit_icon) begin
                icon_q <= icon_wr;
            end
            if (wr_ok && hit_hlo) begin
                h_q[`ISING_APB_DATA_WIDTH-1:0] <= pwdata_i;
            end
            if (wr_ok && hit_hhi) begin
                h_q[`ISING_APB_DATA_WIDTH +: `ISING_APB_DATA_WIDTH] <= pwdata_i;
            end
        end
    end

    // write payload, latched with each accepted write
    always_ff @(posedge clk_i) begin
        if (wr_ok) begin
            spin_wdata_o <= spin_vec_t'(pwdata_i);
            load.wdata   <= pwdata_i;
            load.waddr   <= hit_j ? apb_addr_t'(paddr_i - `ISING_J_BASE)
                                  : apb_addr_t'(paddr_i - `ISING_FLIP_BASE);
        end
    end

    assign h_o          = h_q;
    assign icon_count_o = icon_q;

endmodule

//--- src/ising_load_if.sv
`timescale 1ns/1ps

// memory write traffic, one cycle after the apb access cycle
interface ising_load_if import ising_pkg::*; ();

    logic      j_wen;     // write one half row of J
    logic      flip_wen;  // write one flip mask entry
    apb_addr_t waddr;     // byte offset inside the target region
    apb_data_t wdata;

    modport regs (
        output j_wen,
        output flip_wen,
        output waddr,
        output wdata
    );

    modport engine (
        input j_wen,
        input waddr,
        input wdata
    );

    modport sequencer (
        input flip_wen,
        input waddr,
        input wdata
    );

endinterface

//--- src/ising_pkg.sv
`include "ising_settings.svh"

package ising_pkg;

    // spin state, bit 1 is +1 and bit 0 is -1
    typedef logic [`ISING_NUM_SPIN-1:0] spin_vec_t;

    // one row of the coupling matrix, weight k in bits [4k +: 4]
    typedef logic [`ISING_NUM_SPIN*`ISING_BIT_J-1:0] j_row_t;
    typedef logic [`ISING_BIT_J-1:0]                 j_weight_t;

    // all biases packed, bias i in bits [4i +: 4]
    typedef logic [`ISING_NUM_SPIN*`ISING_BIT_H-1:0] h_vec_t;

    typedef logic signed [`ISING_FIELD_WIDTH-1:0] field_t;    // local field sum

    typedef logic [$clog2(`ISING_NUM_SPIN)-1:0] row_idx_t;

    // flip count runs 0 .. depth, one extra bit
    typedef logic [$clog2(`ISING_FLIP_DEPTH):0] icon_cnt_t;

    // apb
    typedef logic [`ISING_APB_ADDR_WIDTH-1:0] apb_addr_t;
    typedef logic [`ISING_APB_DATA_WIDTH-1:0] apb_data_t;

    // run control
    typedef enum logic [1:0] {
        IDLE,   // waiting, or checking the flip index
        SWEEP,  // field engine busy
        APPLY   // spins <= new spins ^ mask
    } core_state_t;

endpackage

//--- src/ising_settings.svh
`ifndef ISING_SETTINGS_SVH
`define ISING_SETTINGS_SVH

// core sizes
`define ISING_NUM_SPIN        16
`define ISING_BIT_J           4    // signed coupling
`define ISING_BIT_H           4    // signed bias
`define ISING_FLIP_DEPTH      16
`define ISING_FIELD_WIDTH     10   // holds |h| + 16 * |J| with sign

// apb bus
`define ISING_APB_ADDR_WIDTH  12
`define ISING_APB_DATA_WIDTH  32

// memory regions, byte addresses
`define ISING_J_BASE          12'h100   // row r at base + 8r, low word first
`define ISING_FLIP_BASE       12'h200   // entry k at base + 4k

// register offsets
`define ISING_REG_CTRL        12'h000
`define ISING_REG_STATUS      12'h004
`define ISING_REG_ICON_COUNT  12'h008
`define ISING_REG_SPINS       12'h00C
`define ISING_REG_HBIAS_LO    12'h010
`define ISING_REG_HBIAS_HI    12'h014

`endif
